/* wb_cache.f */
design/cache_pkg.sv
design/mem_latency_timer.sv
design/backing_mem.sv
design/cache_data_bank.sv
design/cache_tag_bank.sv
design/cache_ctrl_fsm.sv
design/wb_cache_top.sv
verif/wb_cache_tb.sv

/* verif/wb_cache_tb.sv */
`timescale 1ns/1ps

module wb_cache_tb;

  localparam int NUM_ROWS       = 12;
  localparam int RESET_CYCLES   = 10;
  localparam int SHADOW_WORDS   = 1024;   // all table addresses stay below 4 KB, no aliasing
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (2 * cache_pkg::MEM_LATENCY + 6) + RESET_CYCLES;

  // one table row: operation, address, write word, expected hit
  typedef struct packed {
    logic             write;
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
    logic             exp_hit;
  } row_t;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  req_valid;
  cache_pkg::cache_req_t req;
  logic                  ready;
  logic                  resp_valid;
  cache_pkg::word_t      dout;
  logic                  hit;
  cache_pkg::count_t     hit_count;
  cache_pkg::count_t     miss_count;

  row_t              rows [NUM_ROWS];
  cache_pkg::word_t  shadow [SHADOW_WORDS];   // expected memory image, one entry per word
  int                errs;                    // failed checks in the current test
  int                tests_run;
  int                tests_failed;
  int                cycle_cnt = 0;
  cache_pkg::count_t exp_hits;
  cache_pkg::count_t exp_misses;

  wb_cache_top wb_cache_top_inst (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .ready      (ready),
    .resp_valid (resp_valid),
    .dout       (dout),
    .hit        (hit),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  always #50 clk = ~clk;   // 100 ns period

  // hang guard, sized from the worst case per row
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the cache stopped responding", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic int word_index(input cache_pkg::addr_t addr);
    return int'(addr >> 2);   // word address
  endfunction

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
      errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      errs++;
    end
  endtask

  task automatic check_count(input string name, input cache_pkg::count_t got,
                             input cache_pkg::count_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
      errs++;
    end
  endtask

  task automatic set_row(input int i, input logic write, input cache_pkg::addr_t addr,
                         input logic exp_hit);
    rows[i] = '{write: write, addr: addr, wdata: write ? $urandom : '0, exp_hit: exp_hit};
  endtask

  task automatic finish_test(input string what);
    tests_run++;
    if (errs != 0) tests_failed++;
    else $display("test %0d ok: %s", tests_run, what);
    errs = 0;
  endtask

  // one request from the table, waits for ready, pulses req_valid, waits for resp_valid
  task automatic run_row(input int r);
    row_t row;
    int   lat;
    row = rows[r];
    @(negedge clk);
    while (!ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{addr: row.addr, read: !row.write, write: row.write, din: row.wdata};
    @(posedge clk);                  // acceptance edge
    req_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!resp_valid);
    check_bit("hit", hit, row.exp_hit);
    if (row.exp_hit && lat != 1) begin   // hits answer in the compare cycle
      $display("hit response took %0d cycles instead of one after acceptance", lat);
      errs++;
    end
    if (row.write) shadow[word_index(row.addr)] = row.wdata;
    else check_word("dout", dout, shadow[word_index(row.addr)]);
    finish_test($sformatf("%s 0x%08h hit=%0b", row.write ? "write" : "read ", row.addr, hit));
  endtask

  initial begin
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    errs       = 0;
    tests_run  = 0;
    tests_failed = 0;
    void'($urandom(32'h78884e49));
    set_row(0,  1'b0, 32'h0000_0040, 1'b0);   // cold miss, index 4
    set_row(1,  1'b0, 32'h0000_0048, 1'b1);   // other word, same line
    set_row(2,  1'b1, 32'h0000_0044, 1'b1);   // write hit, line goes dirty
    set_row(3,  1'b0, 32'h0000_0044, 1'b1);
    set_row(4,  1'b0, 32'h0000_0140, 1'b0);   // same index, tag 1, dirty eviction
    set_row(5,  1'b0, 32'h0000_0044, 1'b0);   // back again, data from the write-back
    set_row(6,  1'b1, 32'h0000_0284, 1'b0);   // write miss allocates, index 8
    set_row(7,  1'b0, 32'h0000_0284, 1'b1);
    set_row(8,  1'b0, 32'h0000_0288, 1'b1);
    set_row(9,  1'b0, 32'h0000_0384, 1'b0);   // evicts the write-allocated line
    set_row(10, 1'b0, 32'h0000_0284, 1'b0);
    set_row(11, 1'b0, 32'h0000_0ff0, 1'b0);   // last set
    for (int i = 0; i < SHADOW_WORDS; i++) shadow[i] = cache_pkg::word_t'(i);
    exp_hits   = '0;
    exp_misses = '0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].exp_hit) exp_hits++;
      else exp_misses++;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("ready", ready, 1'b1);          // idle state after reset
    check_bit("resp_valid", resp_valid, 1'b0);
    check_count("hit_count", hit_count, '0);
    check_count("miss_count", miss_count, '0);
    finish_test("reset state");
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    @(negedge clk);
    check_count("hit_count", hit_count, exp_hits);
    check_count("miss_count", miss_count, exp_misses);
    finish_test("hit and miss tallies");
    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* design/wb_cache_top.sv */
`timescale 1ns/1ps

module wb_cache_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  ready,
  output logic                  resp_valid,
  output cache_pkg::word_t      dout,
  output logic                  hit,
  output cache_pkg::count_t     hit_count,
  output cache_pkg::count_t     miss_count
);

  cache_pkg::index_t     index;
  cache_pkg::word_sel_t  word_sel;
  logic                  data_we;
  logic                  fill_sel;
  cache_pkg::line_t      fill_line;
  cache_pkg::line_t      rd_line;
  cache_pkg::word_t      rd_word;
  logic                  tag_we;
  cache_pkg::tag_entry_t wr_entry;
  cache_pkg::tag_entry_t rd_entry;
  logic                  mem_req_valid;
  cache_pkg::mem_req_t   mem_req;
  logic                  mem_ready;
  cache_pkg::line_t      mem_rdata;

  cache_ctrl_fsm ctrl_inst (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .rd_entry      (rd_entry),
    .rd_word       (rd_word),
    .rd_line       (rd_line),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .ready         (ready),
    .resp_valid    (resp_valid),
    .dout          (dout),
    .hit           (hit),
    .hit_count     (hit_count),
    .miss_count    (miss_count),
    .index         (index),
    .word_sel      (word_sel),
    .data_we       (data_we),
    .fill_sel      (fill_sel),
    .fill_line     (fill_line),
    .tag_we        (tag_we),
    .wr_entry      (wr_entry),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req)
  );

  // write word comes from the request, which stays stable until resp_valid
  cache_data_bank data_bank_inst (
    .clk       (clk),
    .reset     (reset),
    .index     (index),
    .word_sel  (word_sel),
    .we        (data_we),
    .fill_sel  (fill_sel),
    .fill_line (fill_line),
    .wr_word   (req.din),
    .rd_line   (rd_line),
    .rd_word   (rd_word)
  );

  cache_tag_bank tag_bank_inst (
    .clk      (clk),
    .reset    (reset),
    .index    (index),
    .we       (tag_we),
    .wr_entry (wr_entry),
    .rd_entry (rd_entry)
  );

  backing_mem mem_inst (
    .clk       (clk),
    .reset     (reset),
    .req_valid (mem_req_valid),
    .req       (mem_req),
    .ready     (mem_ready),
    .rdata     (mem_rdata)
  );

endmodule

/* design/cache_ctrl_fsm.sv */
`timescale 1ns/1ps

module cache_ctrl_fsm (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  input  cache_pkg::tag_entry_t rd_entry,
  input  cache_pkg::word_t      rd_word,
  input  cache_pkg::line_t      rd_line,
  input  logic                  mem_ready,
  input  cache_pkg::line_t      mem_rdata,
  output logic                  ready,
  output logic                  resp_valid,
  output cache_pkg::word_t      dout,
  output logic                  hit,
  output cache_pkg::count_t     hit_count,
  output cache_pkg::count_t     miss_count,
  output cache_pkg::index_t     index,
  output cache_pkg::word_sel_t  word_sel,
  output logic                  data_we,
  output logic                  fill_sel,
  output cache_pkg::line_t      fill_line,
  output logic                  tag_we,
  output cache_pkg::tag_entry_t wr_entry,
  output logic                  mem_req_valid,
  output cache_pkg::mem_req_t   mem_req
);

  cache_pkg::ctrl_state_t state_q, state_d;
  cache_pkg::cache_req_t  req_q;      // request held for the whole transaction
  logic                   miss_q;     // first compare of this request missed
  cache_pkg::tag_t        req_tag;
  logic                   tag_hit;
  logic                   first_miss;

  assign req_tag  = req_q.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign index    = req_q.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign word_sel = req_q.addr[cache_pkg::OFFSET_W-1 -: cache_pkg::WSEL_W];

  assign tag_hit    = rd_entry.valid && (rd_entry.tag == req_tag);
  assign first_miss = (state_q == cache_pkg::compare) && !tag_hit && !miss_q && mem_ready;

  assign ready     = (state_q == cache_pkg::idle);
  assign dout      = rd_word;            // straight from the bank and valid with resp_valid
  assign hit       = tag_hit && !miss_q; // a refilled line still reports the miss
  assign fill_line = mem_rdata;

  always_comb begin
    state_d       = state_q;
    resp_valid    = 1'b0;
    data_we       = 1'b0;
    fill_sel      = 1'b0;
    tag_we        = 1'b0;
    wr_entry      = rd_entry;
    mem_req_valid = 1'b0;
    mem_req       = '0;
    case (state_q)
      cache_pkg::idle: begin
        if (req_valid) state_d = cache_pkg::compare;
      end
      cache_pkg::compare: begin
        if (tag_hit) begin
          resp_valid = 1'b1;
          state_d    = cache_pkg::idle;
          if (req_q.write) begin   // write hit merges the word and marks the line dirty
            data_we  = 1'b1;
            tag_we   = 1'b1;
            wr_entry = '{tag: req_tag, valid: 1'b1, dirty: 1'b1};
          end
        end else if (mem_ready) begin
          mem_req_valid = 1'b1;
          if (rd_entry.valid && rd_entry.dirty) begin
            // victim goes back first with stored tag plus index as its line address
            mem_req = '{line_addr: {rd_entry.tag, index}, read: 1'b0, write: 1'b1,
                        line: rd_line};
            state_d = cache_pkg::write_back;
          end else begin
            mem_req = '{line_addr: req_q.addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                        read: 1'b1, write: 1'b0, line: '0};
            state_d = cache_pkg::allocate;
          end
        end
      end
      cache_pkg::write_back: begin
        if (mem_ready) begin   // victim stored so fetch the wanted line
          mem_req_valid = 1'b1;
          mem_req = '{line_addr: req_q.addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                      read: 1'b1, write: 1'b0, line: '0};
          state_d = cache_pkg::allocate;
        end
      end
      cache_pkg::allocate: begin
        if (mem_ready) begin   // fill data is on mem_rdata this cycle
          data_we  = 1'b1;
          fill_sel = 1'b1;
          tag_we   = 1'b1;
          wr_entry = '{tag: req_tag, valid: 1'b1, dirty: 1'b0};
          state_d  = cache_pkg::compare;
        end
      end
      default: state_d = cache_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= cache_pkg::idle;
      miss_q     <= 1'b0;
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == cache_pkg::idle && req_valid) begin
        miss_q <= 1'b0;   // new request
      end else if (first_miss) begin
        miss_q     <= 1'b1;
        miss_count <= miss_count + 1'b1;   // once per request
      end
      if (state_q == cache_pkg::compare && tag_hit && !miss_q) hit_count <= hit_count + 1'b1;
    end
  end

  // request payload captured at acceptance
  always_ff @(posedge clk) begin
    if (state_q == cache_pkg::idle && req_valid) req_q <= req;
  end

  a_req_in_idle: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> state_q == cache_pkg::idle);

  // memory must be ready on issue and drop ready one cycle later
  a_mem_handshake: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> mem_ready ##1 !mem_ready);

  a_data_we_state: assert property (@(posedge clk) disable iff (reset)
    (data_we || fill_sel) |-> state_q inside {cache_pkg::allocate, cache_pkg::compare});

endmodule

/* design/cache_tag_bank.sv */
`timescale 1ns/1ps

module cache_tag_bank (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::index_t     index,
  input  logic                  we,
  input  cache_pkg::tag_entry_t wr_entry,
  output cache_pkg::tag_entry_t rd_entry
);

  cache_pkg::tag_entry_t entries [cache_pkg::NUM_SETS];

  assign rd_entry = entries[index];   // async read

  // reset invalidates every entry
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].dirty <= 1'b0;
      end
    end else if (we) begin
      entries[index] <= wr_entry;   // tag, valid and dirty together
    end
  end

  // the controller never marks a line dirty without also validating it
  a_dirty_valid: assert property (@(posedge clk) disable iff (reset)
    (we && wr_entry.dirty) |-> wr_entry.valid);

endmodule

/* design/cache_data_bank.sv */
`timescale 1ns/1ps

module cache_data_bank (
  input  logic                 clk,
  input  logic                 reset,
  input  cache_pkg::index_t    index,
  input  cache_pkg::word_sel_t word_sel,
  input  logic                 we,
  input  logic                 fill_sel,
  input  cache_pkg::line_t     fill_line,
  input  cache_pkg::word_t     wr_word,
  output cache_pkg::line_t     rd_line,
  output cache_pkg::word_t     rd_word
);

  cache_pkg::line_t bank [cache_pkg::NUM_SETS];
  cache_pkg::line_t merged;   // stored line with the request word patched in

  assign rd_line = bank[index];   // async read
  assign rd_word = rd_line[word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W];

  always_comb begin
    merged = rd_line;
    merged[word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W] = wr_word;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
        bank[i] <= '0;
      end
    end else if (we) begin
      bank[index] <= fill_sel ? fill_line : merged;   // whole line on fill, one word otherwise
    end
  end

endmodule

/* design/backing_mem.sv */
`timescale 1ns/1ps

module backing_mem (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_valid,
  input  cache_pkg::mem_req_t req,
  output logic                ready,
  output cache_pkg::line_t    rdata
);

  cache_pkg::line_t    mem [cache_pkg::MEM_LINES];
  cache_pkg::line_t    rd_line_q;   // line read at request time
  cache_pkg::mem_idx_t idx;
  logic                busy;
  logic                done;

  // upper line address bits are ignored, so distant lines alias
  assign idx = req.line_addr[cache_pkg::MEM_IDX_W-1:0];

  mem_latency_timer timer_inst (
    .clk   (clk),
    .reset (reset),
    .start (req_valid),
    .busy  (busy),
    .done  (done)
  );

  assign ready = !busy;
  assign rdata = done ? rd_line_q : '0;   // shown only in the cycle the access completes

  always_ff @(posedge clk) begin
    if (reset) begin
      // each word holds its own word address
      for (int i = 0; i < cache_pkg::MEM_LINES; i++) begin
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
          mem[i][w*cache_pkg::WORD_W +: cache_pkg::WORD_W] <=
            cache_pkg::word_t'(i * cache_pkg::WORDS_PER_LINE + w);
        end
      end
    end else if (req_valid) begin
      if (req.write) begin
        mem[idx] <= req.line;   // write-back of a victim
      end
      if (req.read) begin
        rd_line_q <= mem[idx];  // fill read, held until done
      end
    end
  end

  a_one_op: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> (req.read ^ req.write));

endmodule

/* design/mem_latency_timer.sv */
`timescale 1ns/1ps

module mem_latency_timer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic done
);

  cache_pkg::lat_cnt_t cnt_q;   // cycles left, 1 means this is the done cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (start) begin
      cnt_q <= cache_pkg::lat_cnt_t'(cache_pkg::MEM_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;   // stops at zero when idle
    end
  end

  assign done = (cnt_q == cache_pkg::lat_cnt_t'(1));
  assign busy = (cnt_q > cache_pkg::lat_cnt_t'(1));   // low again in the done cycle

  // one access at a time, done lands exactly MEM_LATENCY cycles after start
  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy ##(cache_pkg::MEM_LATENCY) done);

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

  // geometry of the cache and its address split
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORD_W * WORDS_PER_LINE;       // 128 bit line
  localparam int NUM_SETS       = 16;
  localparam int INDEX_W        = $clog2(NUM_SETS);
  localparam int WSEL_W         = $clog2(WORDS_PER_LINE);
  localparam int OFFSET_W       = WSEL_W + 2;                    // byte offset within a line
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;   // 24

  // backing memory model
  localparam int MEM_LATENCY    = 4;     // cycles from request pulse to done
  localparam int MEM_LINES      = 256;
  localparam int MEM_IDX_W      = $clog2(MEM_LINES);  // low line address bits only, rest aliases
  localparam int LAT_W          = $clog2(MEM_LATENCY + 1);

  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [WORD_W-1:0]          word_t;
  typedef logic [LINE_W-1:0]          line_t;
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [INDEX_W-1:0]         index_t;
  typedef logic [WSEL_W-1:0]          word_sel_t;
  typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;   // byte address >> 4
  typedef logic [31:0]                count_t;
  typedef logic [LAT_W-1:0]           lat_cnt_t;
  typedef logic [MEM_IDX_W-1:0]       mem_idx_t;

  typedef struct packed {
    addr_t addr;
    logic  read;
    logic  write;
    word_t din;
  } cache_req_t;   // 66 bits

  typedef struct packed {
    tag_t tag;
    logic valid;
    logic dirty;
  } tag_entry_t;   // 26 bits

  typedef struct packed {
    line_addr_t line_addr;
    logic       read;
    logic       write;
    line_t      line;
  } mem_req_t;   // 158 bits

  typedef enum logic [1:0] {idle, compare, allocate, write_back} ctrl_state_t;

endpackage
